//--- common/codec_cfg.svh
// ######################################
// Sizes and register map of the audio port
// Bit clock divide must be even and at least 4
// Frame divider must cover start plus both
// channels, i.e. at least 2N+1 bit periods
// ######################################
`ifndef CODEC_CFG_SVH
`define CODEC_CFG_SVH

// Local bus
`define CODEC_LB_ADDR_W    8
`define CODEC_LB_DATA_W    16

// Sample and frame sizing
`define CODEC_PCM_W        32      // Full sample word
`define CODEC_FS_DIV_W     11      // Frame length field
`define CODEC_BCLK_DIV     8       // System clocks per bit period

// Register addresses
`define CODEC_CTRL_ADDR    8'h00
`define CODEC_STATUS_ADDR  8'h01
`define CODEC_FS_DIV_ADDR  8'h02

`define CODEC_BAD_READ     16'hdead  // Unmapped address readback

`endif

//--- common/codec_reg_pkg.sv
// ######################################
// Register map types of the audio port
// Control word is {wlen32, adc_en, dac_en}
// Word length resets to 32 bits per sample
// ######################################
`include "codec_cfg.svh"

package codec_reg_pkg;

  // Local bus words
  typedef logic [`CODEC_LB_ADDR_W-1:0] lb_addr_t;
  typedef logic [`CODEC_LB_DATA_W-1:0] lb_data_t;

  // Control register, plain 3-bit field
  typedef logic [2:0] codec_ctrl_t;

  localparam int CTRL_DAC_EN = 0;    // 1 enables DAC path
  localparam int CTRL_ADC_EN = 1;    // 1 enables ADC path
  localparam int CTRL_WLEN32 = 2;    // 1 -> 32 bits, 0 -> 16 bits

  // Both paths off, 32-bit words
  localparam codec_ctrl_t CTRL_RST = 3'b100;

  // Frame length in bit periods
  typedef logic [`CODEC_FS_DIV_W-1:0] fs_div_t;

endpackage

//--- common/codec_pcm_pkg.sv
// ######################################
// Frame state and PCM sample word types
// Sample word decodes as 32 bits or as an
// upper half and a 16-bit lower sample
// ######################################
`include "codec_cfg.svh"

package codec_pcm_pkg;

  // Frame sequencing
  typedef enum logic [2:0]
  {
    FS_IDLE  = 3'd0,   // Waiting for a frame start
    FS_START = 3'd1,   // One bit period, LRC high
    FS_LEFT  = 3'd2,
    FS_RIGHT = 3'd3,
    FS_WAIT  = 3'd4    // Pad until frame divider reached
  } frame_state_e;

  localparam int PCM_HALF_W = `CODEC_PCM_W / 2;

  // Word length bit picks the view
  typedef union packed
  {
    logic [`CODEC_PCM_W-1:0] full;     // 32-bit sample
    struct packed
    {
      logic [PCM_HALF_W-1:0] upper;   // Ignored in 16-bit mode
      logic [PCM_HALF_W-1:0] lower;   // 16-bit sample
    } half;
  } pcm_word_u;

endpackage

//--- verilog/codec_regs.sv
// ######################################
// Local bus register block
// Writes take effect on the strobe cycle
// Reads answer one cycle after lb_rd_en
// ######################################
`include "codec_cfg.svh"

module codec_regs
  (
    input  logic                        clk_ir,
    input  logic                        rst_il,
    input  logic                        lb_rd_en,
    input  logic                        lb_wr_en,
    input  codec_reg_pkg::lb_addr_t     lb_addr,
    input  codec_reg_pkg::lb_data_t     lb_wr_data,
    input  logic                        dac_ready,     // Frame timer idle
    output logic                        lb_rd_valid,
    output logic                        lb_wr_valid,
    output codec_reg_pkg::lb_data_t     lb_rd_data,
    output codec_reg_pkg::codec_ctrl_t  ctrl,
    output codec_reg_pkg::fs_div_t      fs_div
  );

  import codec_reg_pkg::*;

  assign lb_wr_valid = lb_wr_en;  // No write wait states

  // Write decode
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      ctrl   <= CTRL_RST;
      fs_div <= '0;
    end
    else if (lb_wr_en)
    begin
      if (lb_addr == `CODEC_CTRL_ADDR)
        ctrl <= lb_wr_data[$bits(codec_ctrl_t)-1:0];
      if (lb_addr == `CODEC_FS_DIV_ADDR)
        fs_div <= lb_wr_data[`CODEC_FS_DIV_W-1:0];
    end
  end

  // Read strobe echo
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
      lb_rd_valid <= 1'b0;
    else
      lb_rd_valid <= lb_rd_en;
  end

  // Read mux, fields zero padded
  always_ff @(posedge clk_ir)
  begin
    if (lb_rd_en)
    begin
      case (lb_addr)
        `CODEC_CTRL_ADDR:   lb_rd_data <= lb_data_t'(ctrl);
        `CODEC_STATUS_ADDR: lb_rd_data <= lb_data_t'(dac_ready);
        `CODEC_FS_DIV_ADDR: lb_rd_data <= lb_data_t'(fs_div);
        default:            lb_rd_data <= `CODEC_BAD_READ;
      endcase
    end
  end

endmodule

//--- frame/frame_timer.sv
// ######################################
// Bit clock and frame sequencer
// Phase vector free runs from reset
// Bit clock low when both paths disabled
// fs_div below 2N+1 wraps the counter
// ######################################
`include "codec_cfg.svh"

module frame_timer
  (
    input  logic                        clk_ir,
    input  logic                        rst_il,
    input  codec_reg_pkg::codec_ctrl_t  ctrl,
    input  codec_reg_pkg::fs_div_t      fs_div,
    input  logic                        pcm_valid,     // Upstream FIFO not empty
    output logic                        aud_bclk,
    output codec_pcm_pkg::frame_state_e frame_state,
    output logic                        bit_tick,      // Last clock of bit period
    output logic                        mid_tick,      // Clock after bclk rise
    output logic                        ack_slot,      // Clock before bit_tick
    output logic                        chan_done,
    output logic                        dac_ready
  );

  import codec_reg_pkg::*;
  import codec_pcm_pkg::*;

  localparam int DIV = `CODEC_BCLK_DIV;
  localparam fs_div_t LEN32 = fs_div_t'(`CODEC_PCM_W);
  localparam fs_div_t LEN16 = fs_div_t'(`CODEC_PCM_W / 2);

  logic [DIV-1:0] phase_vec;   // One hot bit period phase
  fs_div_t        frame_cnt;   // Bit periods since frame start
  fs_div_t        chan_len;
  logic           bclk_en;
  logic           frame_go;
  frame_state_e   next_state;

  // Tick taps off the phase vector
  assign bit_tick = phase_vec[DIV-1];
  assign ack_slot = phase_vec[DIV-2];
  assign mid_tick = phase_vec[DIV/2];

  assign bclk_en   = ctrl[CTRL_DAC_EN] | ctrl[CTRL_ADC_EN];
  assign chan_len  = ctrl[CTRL_WLEN32] ? LEN32 : LEN16;
  assign frame_go  = (ctrl[CTRL_DAC_EN] & pcm_valid) | ctrl[CTRL_ADC_EN];  // DAC needs a pair
  assign dac_ready = (frame_state == FS_IDLE);

  // Rotate phase, drive bclk
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      phase_vec <= DIV'(1);
      aud_bclk  <= 1'b0;
    end
    else
    begin
      phase_vec <= {phase_vec[DIV-2:0], phase_vec[DIV-1]};
      if (!bclk_en)
        aud_bclk <= 1'b0;
      else if (phase_vec[DIV/2-1])
        aud_bclk <= 1'b1;          // Rise mid period
      else if (bit_tick)
        aud_bclk <= 1'b0;          // Fall at period boundary
    end
  end

  // Frame counter, held at 0 in idle
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
      frame_cnt <= '0;
    else if (frame_state == FS_IDLE)
      frame_cnt <= '0;
    else if (bit_tick)
      frame_cnt <= frame_cnt + 1'b1;
  end

  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
      frame_state <= FS_IDLE;
    else
      frame_state <= next_state;
  end

  // Next state and channel end
  always_comb
  begin
    next_state = frame_state;
    chan_done  = 1'b0;
    case (frame_state)
      FS_IDLE:
        if (bit_tick && frame_go)
          next_state = FS_START;
      FS_START:
        if (bit_tick)
          next_state = FS_LEFT;
      FS_LEFT:
      begin
        chan_done = bit_tick && (frame_cnt == chan_len);     // Counter is 1 on first left bit
        if (chan_done)
          next_state = FS_RIGHT;
      end
      FS_RIGHT:
      begin
        chan_done = bit_tick && (frame_cnt == (chan_len << 1));
        if (chan_done)
          next_state = FS_WAIT;
      end
      FS_WAIT:
        if (frame_cnt == fs_div)
          next_state = FS_IDLE;
      default:
        next_state = FS_IDLE;
    endcase
  end

endmodule

//--- frame/dac_serializer.sv
// ######################################
// DAC shift out with MSB first
// Takes one FIFO pair per frame in start
// A dry FIFO leaves zeros to shift out
// ######################################
`include "codec_cfg.svh"

module dac_serializer
  (
    input  logic                        clk_ir,
    input  logic                        rst_il,
    input  codec_reg_pkg::codec_ctrl_t  ctrl,
    input  codec_pcm_pkg::frame_state_e frame_state,
    input  logic                        bit_tick,
    input  logic                        ack_slot,
    input  logic                        pcm_valid,
    input  codec_pcm_pkg::pcm_word_u    pcm_ldata,
    input  codec_pcm_pkg::pcm_word_u    pcm_rdata,
    output logic                        pcm_ack,
    output logic                        aud_dac_dat,
    output logic                        aud_dac_lrc
  );

  import codec_reg_pkg::*;
  import codec_pcm_pkg::*;

  pcm_word_u l_shift;
  pcm_word_u r_shift;
  logic      dac_en;
  logic      l_msb;
  logic      r_msb;

  assign dac_en = ctrl[CTRL_DAC_EN];

  // MSB of the active view
  assign l_msb = ctrl[CTRL_WLEN32] ? l_shift.full[`CODEC_PCM_W-1]
                                   : l_shift.half.lower[PCM_HALF_W-1];
  assign r_msb = ctrl[CTRL_WLEN32] ? r_shift.full[`CODEC_PCM_W-1]
                                   : r_shift.half.lower[PCM_HALF_W-1];

  // Ack lands on the last start cycle
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
      pcm_ack <= 1'b0;
    else
      pcm_ack <= dac_en && pcm_valid && ack_slot && (frame_state == FS_START);
  end

  always_ff @(posedge clk_ir)
  begin
    if (frame_state == FS_START && pcm_ack)
    begin
      l_shift <= pcm_ldata;
      r_shift <= pcm_rdata;
    end
    else if (frame_state == FS_LEFT && bit_tick)
      l_shift.full <= {l_shift.full[`CODEC_PCM_W-2:0], 1'b0};
    else if (frame_state == FS_RIGHT && bit_tick)
      r_shift.full <= {r_shift.full[`CODEC_PCM_W-2:0], 1'b0};
  end

  // Pins held quiet when disabled
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      aud_dac_dat <= 1'b0;
      aud_dac_lrc <= 1'b0;
    end
    else
    begin
      aud_dac_lrc <= dac_en && (frame_state == FS_START);
      if (!dac_en)
        aud_dac_dat <= 1'b0;
      else if (frame_state == FS_LEFT)
        aud_dac_dat <= l_msb;
      else if (frame_state == FS_RIGHT)
        aud_dac_dat <= r_msb;
      else
        aud_dac_dat <= 1'b0;     // Idle line low between frames
    end
  end

endmodule

//--- frame/adc_deserializer.sv
// ######################################
// ADC shift in and sample strobe
// Line sampled one clock after bclk rises
// 16-bit samples come out sign extended
// Strobe has no back-pressure
// ######################################
`include "codec_cfg.svh"

module adc_deserializer
  (
    input  logic                        clk_ir,
    input  logic                        rst_il,
    input  codec_reg_pkg::codec_ctrl_t  ctrl,
    input  codec_pcm_pkg::frame_state_e frame_state,
    input  logic                        mid_tick,
    input  logic                        chan_done,
    input  logic                        aud_adc_dat,
    output logic                        aud_adc_lrc,
    output logic                        adc_pcm_valid,
    output codec_pcm_pkg::pcm_word_u    adc_lpcm,
    output codec_pcm_pkg::pcm_word_u    adc_rpcm
  );

  import codec_reg_pkg::*;
  import codec_pcm_pkg::*;

  logic adc_en;
  logic right_done_d1;   // First stage of strobe delay

  assign adc_en = ctrl[CTRL_ADC_EN];

  // LRC and strobe pipeline
  always_ff @(posedge clk_ir or negedge rst_il)
  begin
    if (!rst_il)
    begin
      aud_adc_lrc   <= 1'b0;
      right_done_d1 <= 1'b0;
      adc_pcm_valid <= 1'b0;
    end
    else
    begin
      aud_adc_lrc   <= adc_en && (frame_state == FS_START);
      right_done_d1 <= adc_en && chan_done && (frame_state == FS_RIGHT);  // Left end ignored
      adc_pcm_valid <= adc_en && right_done_d1;
    end
  end

  // Sample registers
  always_ff @(posedge clk_ir)
  begin
    if (adc_en)
    begin
      if (right_done_d1 && !ctrl[CTRL_WLEN32])
      begin
        // Widen lower view, ready with the strobe
        adc_lpcm <= {{PCM_HALF_W{adc_lpcm.half.lower[PCM_HALF_W-1]}}, adc_lpcm.half.lower};
        adc_rpcm <= {{PCM_HALF_W{adc_rpcm.half.lower[PCM_HALF_W-1]}}, adc_rpcm.half.lower};
      end
      else if (mid_tick)
      begin
        if (frame_state == FS_LEFT)
          adc_lpcm.full <= {adc_lpcm.full[`CODEC_PCM_W-2:0], aud_adc_dat};
        if (frame_state == FS_RIGHT)
          adc_rpcm.full <= {adc_rpcm.full[`CODEC_PCM_W-2:0], aud_adc_dat};
      end
    end
  end

endmodule

//--- verilog/codec_port.sv
// ######################################
// Serial audio port of the stereo codec
// One PCM pair out and one in per frame
// Registers reached over the local bus
// ######################################
module codec_port
  (
    input  logic                      clk_ir,
    input  logic                      rst_il,
    // Local bus
    input  logic                      lb_rd_en,
    input  logic                      lb_wr_en,
    input  codec_reg_pkg::lb_addr_t   lb_addr,
    input  codec_reg_pkg::lb_data_t   lb_wr_data,
    output logic                      lb_rd_valid,
    output logic                      lb_wr_valid,
    output codec_reg_pkg::lb_data_t   lb_rd_data,
    // Upstream PCM FIFO
    input  logic                      pcm_valid,
    input  codec_pcm_pkg::pcm_word_u  pcm_ldata,
    input  codec_pcm_pkg::pcm_word_u  pcm_rdata,
    output logic                      pcm_ack,
    // ADC samples
    output logic                      adc_pcm_valid,
    output codec_pcm_pkg::pcm_word_u  adc_lpcm,
    output codec_pcm_pkg::pcm_word_u  adc_rpcm,
    // Codec pins
    output logic                      aud_bclk,
    output logic                      aud_dac_dat,
    output logic                      aud_dac_lrc,
    output logic                      aud_adc_lrc,
    input  logic                      aud_adc_dat
  );

  import codec_reg_pkg::*;
  import codec_pcm_pkg::*;

  codec_ctrl_t  ctrl;
  fs_div_t      fs_div;
  logic         dac_ready;
  frame_state_e frame_state;
  logic         bit_tick;
  logic         mid_tick;
  logic         ack_slot;
  logic         chan_done;

  codec_regs regs0
    (
      .clk_ir      (clk_ir),
      .rst_il      (rst_il),
      .lb_rd_en    (lb_rd_en),
      .lb_wr_en    (lb_wr_en),
      .lb_addr     (lb_addr),
      .lb_wr_data  (lb_wr_data),
      .dac_ready   (dac_ready),
      .lb_rd_valid (lb_rd_valid),
      .lb_wr_valid (lb_wr_valid),
      .lb_rd_data  (lb_rd_data),
      .ctrl        (ctrl),
      .fs_div      (fs_div)
    );

  frame_timer timer0
    (
      .clk_ir      (clk_ir),
      .rst_il      (rst_il),
      .ctrl        (ctrl),
      .fs_div      (fs_div),
      .pcm_valid   (pcm_valid),
      .aud_bclk    (aud_bclk),
      .frame_state (frame_state),
      .bit_tick    (bit_tick),
      .mid_tick    (mid_tick),
      .ack_slot    (ack_slot),
      .chan_done   (chan_done),
      .dac_ready   (dac_ready)
    );

  dac_serializer dac0
    (
      .clk_ir      (clk_ir),
      .rst_il      (rst_il),
      .ctrl        (ctrl),
      .frame_state (frame_state),
      .bit_tick    (bit_tick),
      .ack_slot    (ack_slot),
      .pcm_valid   (pcm_valid),
      .pcm_ldata   (pcm_ldata),
      .pcm_rdata   (pcm_rdata),
      .pcm_ack     (pcm_ack),
      .aud_dac_dat (aud_dac_dat),
      .aud_dac_lrc (aud_dac_lrc)
    );

  adc_deserializer adc0
    (
      .clk_ir        (clk_ir),
      .rst_il        (rst_il),
      .ctrl          (ctrl),
      .frame_state   (frame_state),
      .mid_tick      (mid_tick),
      .chan_done     (chan_done),
      .aud_adc_dat   (aud_adc_dat),
      .aud_adc_lrc   (aud_adc_lrc),
      .adc_pcm_valid (adc_pcm_valid),
      .adc_lpcm      (adc_lpcm),
      .adc_rpcm      (adc_rpcm)
    );

endmodule

//--- testbench/codec_port_assertions.sv
// ########################################
// Concurrent checks bound into codec_port
// Reaches the internal ctrl word
// All checks idle while rst_il is low
// ########################################
module codec_port_assertions
  (
    input logic                        clk_ir,
    input logic                        rst_il,
    input codec_reg_pkg::codec_ctrl_t  ctrl,
    input logic                        pcm_valid,
    input logic                        pcm_ack,
    input logic                        adc_pcm_valid,
    input logic                        aud_bclk,
    input logic                        aud_dac_dat,
    input logic                        aud_dac_lrc
  );

  import codec_reg_pkg::*;

  logic bclk_en;
  int   fail_count = 0;   // Assertion failures so far

  assign bclk_en = ctrl[CTRL_DAC_EN] | ctrl[CTRL_ADC_EN];

  ack_needs_valid: assert property (@(posedge clk_ir) disable iff (!rst_il)
      pcm_ack |-> pcm_valid)
    else
    begin
      $error("pcm_ack while pcm_valid low");
      fail_count++;
    end

  // No strobe while the ADC is off
  adc_strobe_enabled: assert property (@(posedge clk_ir) disable iff (!rst_il)
      adc_pcm_valid |-> ctrl[CTRL_ADC_EN])
    else
    begin
      $error("adc_pcm_valid with ADC disabled");
      fail_count++;
    end

  dac_quiet: assert property (@(posedge clk_ir) disable iff (!rst_il)
      !ctrl[CTRL_DAC_EN] |-> (!aud_dac_dat && !aud_dac_lrc))
    else
    begin
      $error("DAC pins active with DAC disabled");
      fail_count++;
    end

  // A disable may cut the high phase so only natural falls count
  bclk_high_four: assert property (@(posedge clk_ir) disable iff (!rst_il)
      ($fell(aud_bclk) && bclk_en) |->
        ($past(aud_bclk, 2) && $past(aud_bclk, 3) && $past(aud_bclk, 4)
         && !$past(aud_bclk, 5)))
    else
    begin
      $error("Bit clock high phase not 4 cycles");
      fail_count++;
    end

endmodule

bind codec_port codec_port_assertions chk0
  (
    .clk_ir        (clk_ir),
    .rst_il        (rst_il),
    .ctrl          (ctrl),
    .pcm_valid     (pcm_valid),
    .pcm_ack       (pcm_ack),
    .adc_pcm_valid (adc_pcm_valid),
    .aud_bclk      (aud_bclk),
    .aud_dac_dat   (aud_dac_dat),
    .aud_dac_lrc   (aud_dac_lrc)
  );

//--- testbench/tb_codec_port.sv
// ########################################
// Trace driven testbench for codec_port
// Reads testbench/codec_trace.txt, run from
// the project root
// One frame per trace record, DAC and ADC on
// Serial pins sampled on clk_ir edges only
// ########################################
`include "codec_cfg.svh"

module tb_codec_port;

  import codec_reg_pkg::*;
  import codec_pcm_pkg::*;

  logic      clk_ir;
  logic      rst_il;
  logic      lb_rd_en;
  logic      lb_wr_en;
  lb_addr_t  lb_addr;
  lb_data_t  lb_wr_data;
  logic      lb_rd_valid;
  logic      lb_wr_valid;
  lb_data_t  lb_rd_data;
  logic      pcm_valid;
  pcm_word_u pcm_ldata;
  pcm_word_u pcm_rdata;
  logic      pcm_ack;
  logic      adc_pcm_valid;
  pcm_word_u adc_lpcm;
  pcm_word_u adc_rpcm;
  logic      aud_bclk;
  logic      aud_dac_dat;
  logic      aud_dac_lrc;
  logic      aud_adc_lrc;
  logic      aud_adc_dat;

  logic [31:0] fifo_l[$];     // Upstream pairs not yet taken
  logic [31:0] fifo_r[$];
  int          ack_count;
  int          errors;
  int          tests;
  int          failed_tests;

  codec_port dut0
    (
      .clk_ir        (clk_ir),
      .rst_il        (rst_il),
      .lb_rd_en      (lb_rd_en),
      .lb_wr_en      (lb_wr_en),
      .lb_addr       (lb_addr),
      .lb_wr_data    (lb_wr_data),
      .lb_rd_valid   (lb_rd_valid),
      .lb_wr_valid   (lb_wr_valid),
      .lb_rd_data    (lb_rd_data),
      .pcm_valid     (pcm_valid),
      .pcm_ldata     (pcm_ldata),
      .pcm_rdata     (pcm_rdata),
      .pcm_ack       (pcm_ack),
      .adc_pcm_valid (adc_pcm_valid),
      .adc_lpcm      (adc_lpcm),
      .adc_rpcm      (adc_rpcm),
      .aud_bclk      (aud_bclk),
      .aud_dac_dat   (aud_dac_dat),
      .aud_dac_lrc   (aud_dac_lrc),
      .aud_adc_lrc   (aud_adc_lrc),
      .aud_adc_dat   (aud_adc_dat)
    );

  always #4 clk_ir = ~clk_ir;   // 8 unit period

  // Upstream FIFO model shows its head until acked
  always @(posedge clk_ir)
  begin
    if (pcm_ack && pcm_valid)
    begin
      fifo_l.delete(0);
      fifo_r.delete(0);
      ack_count++;
    end
    if (fifo_l.size() > 0)
    begin
      pcm_valid <= 1'b1;
      pcm_ldata <= fifo_l[0];
      pcm_rdata <= fifo_r[0];
    end
    else
      pcm_valid <= 1'b0;
  end

  // Serial bit i of a frame with left word and MSB first
  function automatic logic stream_bit(input logic [31:0] l, input logic [31:0] r,
                                      input int n, input int i);
    if (i < n)
      return l[n-1-i];
    return r[2*n-1-i];
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors != errs_before)
      failed_tests++;
    $display("%s: %s", name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic write_reg(input lb_addr_t addr, input lb_data_t data);
    @(posedge clk_ir);
    lb_wr_en   <= 1'b1;
    lb_addr    <= addr;
    lb_wr_data <= data;
    @(posedge clk_ir);
    if (lb_wr_valid !== 1'b1)
      report_mismatch("lb_wr_valid echo", lb_wr_valid, 1);
    lb_wr_en <= 1'b0;
  endtask

  // Answer due exactly one cycle after the strobe
  task automatic read_reg(input lb_addr_t addr, output lb_data_t data);
    @(posedge clk_ir);
    lb_rd_en <= 1'b1;
    lb_addr  <= addr;
    @(posedge clk_ir);
    lb_rd_en <= 1'b0;
    @(posedge clk_ir);
    if (lb_rd_valid !== 1'b1)
      report_mismatch("lb_rd_valid one cycle after read", lb_rd_valid, 1);
    data = lb_rd_data;
  endtask

  task automatic wait_idle();
    lb_data_t rd;
    int       tries;
    rd    = '0;
    tries = 0;
    while (rd !== 16'h0001 && tries < 400)
    begin
      read_reg(`CODEC_STATUS_ADDR, rd);
      tries++;
    end
    if (rd !== 16'h0001)
    begin
      $display("Timed out waiting for the frame timer to return to idle");
      errors++;
    end
  endtask

  task automatic register_access();
    lb_data_t rd;
    int       errs_before;
    errs_before = errors;
    read_reg(`CODEC_STATUS_ADDR, rd);
    if (rd !== 16'h0001)
      report_mismatch("status after reset", rd, 32'h1);
    read_reg(`CODEC_CTRL_ADDR, rd);
    if (rd !== 16'h0004)
      report_mismatch("ctrl reset value", rd, 32'h4);
    write_reg(`CODEC_CTRL_ADDR, 16'h0000);
    read_reg(`CODEC_CTRL_ADDR, rd);
    if (rd !== 16'h0000)
      report_mismatch("ctrl readback", rd, 32'h0);
    write_reg(`CODEC_CTRL_ADDR, 16'hfffc);   // Only 3 bits kept so enables stay clear
    read_reg(`CODEC_CTRL_ADDR, rd);
    if (rd !== 16'h0004)
      report_mismatch("ctrl readback padded", rd, 32'h4);
    write_reg(`CODEC_FS_DIV_ADDR, 16'hf7a5); // 11-bit field
    read_reg(`CODEC_FS_DIV_ADDR, rd);
    if (rd !== 16'h07a5)
      report_mismatch("fs_div readback padded", rd, 32'h7a5);
    read_reg(8'h37, rd);
    if (rd !== 16'hdead)
      report_mismatch("unmapped read", rd, 32'hdead);
    read_reg(8'hff, rd);
    if (rd !== 16'hdead)
      report_mismatch("unmapped read", rd, 32'hdead);
    finish_test("register access", errs_before);
  endtask

  // One frame with both paths enabled
  task automatic run_frame(input int rec, input logic wlen, input logic [10:0] fsd,
                           input logic [31:0] dl, input logic [31:0] dr,
                           input logic [31:0] al, input logic [31:0] ar,
                           input logic [31:0] el, input logic [31:0] er);
    int          n;
    int          cyc;
    int          dac_cnt;
    int          adc_idx;
    int          acks_before;
    int          errs_before;
    logic        bclk_p;
    logic        dlrc_p;
    logic        alrc_p;
    logic        dac_arm;
    logic        adc_arm;
    logic        got_adc;
    logic [31:0] cap_l;
    logic [31:0] cap_r;
    logic [31:0] adc_l;
    logic [31:0] adc_r;
    errs_before = errors;
    n           = wlen ? 32 : 16;
    cyc         = 0;
    dac_cnt     = 0;
    adc_idx     = 0;
    bclk_p      = 1'b0;
    dlrc_p      = 1'b0;
    alrc_p      = 1'b0;
    dac_arm     = 1'b0;
    adc_arm     = 1'b0;
    got_adc     = 1'b0;
    cap_l       = '0;
    cap_r       = '0;
    adc_l       = '0;
    adc_r       = '0;
    write_reg(`CODEC_FS_DIV_ADDR, lb_data_t'(fsd));
    @(negedge clk_ir);
    fifo_l.push_back(dl);
    fifo_r.push_back(dr);
    acks_before = ack_count;
    write_reg(`CODEC_CTRL_ADDR, {13'h0, wlen, 2'b11});
    while (!(got_adc && dac_cnt == 2 * n) && cyc < 2000)
    begin
      @(posedge clk_ir);
      cyc++;
      if (dlrc_p && !aud_dac_lrc)
        dac_arm = 1'b1;
      // Capture DAC bit on bclk rise
      if (dac_arm && !bclk_p && aud_bclk && dac_cnt < 2 * n)
      begin
        if (dac_cnt < n)
          cap_l = {cap_l[30:0], aud_dac_dat};
        else
          cap_r = {cap_r[30:0], aud_dac_dat};
        dac_cnt++;
      end
      // First ADC bit on LRC fall and the rest on bclk fall
      if (alrc_p && !aud_adc_lrc)
      begin
        adc_arm = 1'b1;
        aud_adc_dat <= stream_bit(al, ar, n, 0);
        adc_idx = 1;
      end
      else if (adc_arm && bclk_p && !aud_bclk && adc_idx < 2 * n)
      begin
        aud_adc_dat <= stream_bit(al, ar, n, adc_idx);
        adc_idx++;
      end
      if (adc_pcm_valid)
      begin
        got_adc = 1'b1;
        adc_l   = adc_lpcm;
        adc_r   = adc_rpcm;
      end
      bclk_p = aud_bclk;
      dlrc_p = aud_dac_lrc;
      alrc_p = aud_adc_lrc;
    end
    if (!(got_adc && dac_cnt == 2 * n))
    begin
      $display("Timed out in frame %0d after %0d DAC bits, ADC strobe seen %0b",
               rec, dac_cnt, got_adc);
      errors++;
    end
    else
    begin
      if (cap_l !== (wlen ? dl : {16'h0, dl[15:0]}))
        report_mismatch("DAC left word", cap_l, wlen ? dl : {16'h0, dl[15:0]});
      if (cap_r !== (wlen ? dr : {16'h0, dr[15:0]}))
        report_mismatch("DAC right word", cap_r, wlen ? dr : {16'h0, dr[15:0]});
      if (adc_l !== el)
        report_mismatch("ADC left word", adc_l, el);
      if (adc_r !== er)
        report_mismatch("ADC right word", adc_r, er);
    end
    if (ack_count - acks_before != 1)
      report_mismatch("pcm_ack count per frame", ack_count - acks_before, 1);
    write_reg(`CODEC_CTRL_ADDR, 16'h0004);
    wait_idle();
    finish_test($sformatf("frame %0d, %0d-bit", rec, n), errs_before);
  endtask

  task automatic play_trace();
    int          fd;
    int          cnt;
    int          rec;
    string       line;
    logic [31:0] wlen;
    logic [31:0] fsd;
    logic [31:0] dl;
    logic [31:0] dr;
    logic [31:0] al;
    logic [31:0] ar;
    logic [31:0] el;
    logic [31:0] er;
    rec = 0;
    fd  = $fopen("testbench/codec_trace.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open testbench/codec_trace.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;                                  // Column notes
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h", wlen, fsd, dl, dr, al, ar, el, er);
      if (cnt != 8)
      begin
        $display("Malformed trace record: %s", line);
        errors++;
      end
      else
      begin
        rec++;
        run_frame(rec, wlen[0], fsd[10:0], dl, dr, al, ar, el, er);
      end
    end
    $fclose(fd);
    if (rec == 0)
    begin
      $display("Trace file held no records");
      errors++;
    end
  endtask

  // Pair waiting upstream must not leak out
  task automatic quiet_when_disabled();
    int cyc;
    int errs_before;
    errs_before = errors;
    write_reg(`CODEC_CTRL_ADDR, 16'h0000);
    wait_idle();
    @(negedge clk_ir);
    fifo_l.push_back(32'h5a5a_0ff0);
    fifo_r.push_back(32'h0ff0_5a5a);
    @(posedge clk_ir);
    for (cyc = 0; cyc < 200; cyc++)
    begin
      @(posedge clk_ir);
      if (!pcm_valid)
      begin
        $display("FIFO model dropped pcm_valid during the disabled window");
        errors++;
      end
      if (aud_bclk || aud_dac_lrc || aud_adc_lrc || pcm_ack || aud_dac_dat)
        report_mismatch("{bclk, dac_lrc, adc_lrc, ack, dac_dat} while disabled",
                        {aud_bclk, aud_dac_lrc, aud_adc_lrc, pcm_ack, aud_dac_dat}, 0);
    end
    finish_test("disabled outputs", errs_before);
  endtask

  initial
  begin
    clk_ir       = 1'b0;
    rst_il       = 1'b0;
    lb_rd_en     = 1'b0;
    lb_wr_en     = 1'b0;
    lb_addr      = '0;
    lb_wr_data   = '0;
    pcm_valid    = 1'b0;
    pcm_ldata    = '0;
    pcm_rdata    = '0;
    aud_adc_dat  = 1'b0;
    ack_count    = 0;
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    repeat (2) @(posedge clk_ir);
    rst_il <= 1'b1;
    register_access();
    play_trace();
    quiet_when_disabled();
    if (dut0.chk0.fail_count != 0)
    begin
      $display("Bound assertions failed %0d times", dut0.chk0.fail_count);
      errors += dut0.chk0.fail_count;
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- testbench/codec_trace.txt
# wlen32 fs_div dac_left dac_right adc_left_sent adc_right_sent adc_left_exp adc_right_exp
# all hex, 16-bit records send the lower half and expect it sign extended
1 041 a5a5f00f 12345678 deadbeef 0f1e2d3c deadbeef 0f1e2d3c
1 048 80000001 7ffffffe c3c3a5a5 00000001 c3c3a5a5 00000001
0 021 ffff1234 0000abcd 00008001 ffff7ffe ffff8001 00007ffe
0 030 13579bdf 2468ace0 12340f0f 5678f0f0 00000f0f fffff0f0
1 050 ffffffff 00000000 80000000 7fffffff 80000000 7fffffff
0 022 00008000 00007fff 0000ffff 00000000 ffffffff 00000000

//--- list.f
+incdir+common
common/codec_reg_pkg.sv
common/codec_pcm_pkg.sv
verilog/codec_regs.sv
frame/frame_timer.sv
frame/dac_serializer.sv
frame/adc_deserializer.sv
verilog/codec_port.sv
testbench/codec_port_assertions.sv
testbench/tb_codec_port.sv

//--- Bender.yml
package:
  name: codec_port

sources:
  - include_dirs:
      - common
    files:
      - common/codec_reg_pkg.sv
      - common/codec_pcm_pkg.sv
      - verilog/codec_regs.sv
      - frame/frame_timer.sv
      - frame/dac_serializer.sv
      - frame/adc_deserializer.sv
      - verilog/codec_port.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/codec_port_assertions.sv
      - testbench/tb_codec_port.sv
